//--- Makefile
# Verilator flow for the circle drawer
VERILATOR  ?= verilator
TOP        ?= circle_tb
RTL_TOP    ?= circle_top
FILELIST   ?= circle_top.f
VECTORS    ?= verif/circle_vectors.txt
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
RTL_SRC := $(filter source/%,$(SOURCES))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: $(SIM_BIN) $(VECTORS)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRC)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- circle_top.f
source/circle_pkg.sv
source/circle_cmd.sv
source/screen_clear.sv
source/circle_octants.sv
source/pixel_clip.sv
source/circle_top.sv
verif/circle_tb.sv

//--- source/circle_cmd.sv
`timescale 1ns/1ps

module circle_cmd import circle_pkg::*; (
    input  logic        vif,
    input  logic        arst_n,
    input  logic        start,
    input  circle_req_t req_in,
    output logic        done,
    output circle_req_t req,
    output logic        clear_go,
    output logic        draw_go,
    input  logic        clear_fin,
    input  logic        draw_fin,
    output logic        drawing
);

    cmd_state_t state;
    // Holds done back one cycle so the last plot leaves the output register
    logic       fin_q;

    always_ff @(posedge vif or negedge arst_n) begin
        if (!arst_n) begin
            state    <= cmd_idle;
            clear_go <= 1'b0;
            draw_go  <= 1'b0;
            fin_q    <= 1'b0;
        end else begin
            // Go strobes are single-cycle pulses
            clear_go <= 1'b0;
            draw_go  <= 1'b0;
            fin_q    <= 1'b0;
            case (state)
                cmd_idle: begin
                    if (start) begin
                        // Straight to drawing when the old frame is kept
                        if (req_in.skip_clear) begin
                            state   <= cmd_draw;
                            draw_go <= 1'b1;
                        end else begin
                            state    <= cmd_clear;
                            clear_go <= 1'b1;
                        end
                    end
                end
                cmd_clear: begin
                    if (clear_fin) begin
                        state   <= cmd_draw;
                        draw_go <= 1'b1;
                    end
                end
                cmd_draw: begin
                    fin_q <= draw_fin;
                    if (fin_q) begin
                        state <= cmd_done;
                    end
                end
                cmd_done: begin
                    // Caller drops start to release done
                    if (!start) begin
                        state <= cmd_idle;
                    end
                end
                default: state <= cmd_idle;
            endcase
        end
    end

    // Request is sampled once, on acceptance
    always_ff @(posedge vif) begin
        if (state == cmd_idle && start) begin
            req <= req_in;
        end
    end

    assign done    = (state == cmd_done);
    // Steers the pixel mux to the circle engine and request colour
    assign drawing = (state == cmd_draw);

endmodule

//--- source/circle_octants.sv
`timescale 1ns/1ps

module circle_octants import circle_pkg::*; (
    input  logic        vif,
    input  logic        arst_n,
    input  logic        draw_go,
    input  circle_req_t req,
    output logic        draw_fin,
    output logic        pt_valid,
    output point_t      pt
);

    oct_state_t         state;
    // Which of the eight octant points goes out this cycle
    logic [2:0]         idx;

    // Midpoint variables, a along the axis, b across it
    scoord_t            a;
    scoord_t            b;
    // Decision term, wider than the coordinates
    logic signed [11:0] d;

    // Next step values
    scoord_t            a_nxt;
    scoord_t            b_nxt;
    logic signed [11:0] a_ext;
    logic signed [11:0] b_ext;
    logic signed [11:0] d_nxt;
    logic               last_step;

    // Centre and the swapped offset pair
    scoord_t            cx;
    scoord_t            cy;
    scoord_t            u;
    scoord_t            v;

    assign b_nxt = b + 10'sd1;
    // a only moves inward when d is non-negative
    assign a_nxt = d[11] ? a : a - 10'sd1;

    // Sign-extend for the decision update
    assign a_ext = {{2{a_nxt[9]}}, a_nxt};
    assign b_ext = {{2{b_nxt[9]}}, b_nxt};

    // d + 2b + 1, or d + 2(b - a) + 1, with the updated a and b
    assign d_nxt = d[11] ? d + (b_ext <<< 1) + 12'sd1
                         : d + ((b_ext - a_ext) <<< 1) + 12'sd1;

    // Octant crossed, nothing left to draw
    assign last_step = (b_nxt > a_nxt);

    // Control
    always_ff @(posedge vif or negedge arst_n) begin
        if (!arst_n) begin
            state <= oct_idle;
            idx   <= '0;
        end else begin
            case (state)
                oct_idle: begin
                    if (draw_go) begin
                        state <= oct_emit;
                        idx   <= '0;
                    end
                end
                oct_emit: begin
                    // idx wraps to 0 for the next step
                    idx <= idx + 3'd1;
                    if (idx == 3'd7) begin
                        state <= last_step ? oct_idle : oct_step;
                    end
                end
                oct_step: begin
                    state <= oct_emit;
                end
                default: state <= oct_idle;
            endcase
        end
    end

    // Algorithm registers, loaded on go and updated once per step
    always_ff @(posedge vif) begin
        if (state == oct_idle && draw_go) begin
            a <= {2'b00, req.radius};
            b <= '0;
            d <= 12'sd1 - signed'({4'b0000, req.radius});
        end else if (state == oct_step) begin
            a <= a_nxt;
            b <= b_nxt;
            d <= d_nxt;
        end
    end

    assign cx = {2'b00, req.centre_x};
    assign cy = {3'b000, req.centre_y};

    // First four points use (a, b), last four use (b, a)
    assign u = idx[2] ? b : a;
    assign v = idx[2] ? a : b;

    // Sign order ++, -+, +-, --
    assign pt.x = idx[0] ? cx - u : cx + u;
    assign pt.y = idx[1] ? cy - v : cy + v;

    assign pt_valid = (state == oct_emit);
    // Marks the last point of the final step
    assign draw_fin = pt_valid && (idx == 3'd7) && last_step;

endmodule

//--- source/circle_pkg.sv
package circle_pkg;

    // Visible screen in pixels
    localparam int scr_w = 160;
    localparam int scr_h = 120;

    // On-screen coordinates
    typedef logic [7:0] xcoord_t;
    typedef logic [6:0] ycoord_t;

    typedef logic [7:0] radius_t;

    // 3-bit RGB, zero is black
    typedef logic [2:0] colour_t;

    // Point before clipping, covers -255 to 510
    typedef logic signed [9:0] scoord_t;

    // One draw request, held for the whole operation
    typedef struct packed {
        xcoord_t centre_x;
        ycoord_t centre_y;
        radius_t radius;
        colour_t colour;
        logic    skip_clear;
    } circle_req_t;

    // Candidate pixel from either engine
    typedef struct packed {
        scoord_t x;
        scoord_t y;
    } point_t;

    // Request sequencing
    typedef enum logic [1:0] {
        cmd_idle,
        cmd_clear,
        cmd_draw,
        cmd_done
    } cmd_state_t;

    // Midpoint engine
    typedef enum logic [1:0] {
        oct_idle,
        oct_emit,
        oct_step
    } oct_state_t;

endpackage

//--- source/circle_top.sv
`timescale 1ns/1ps

module circle_top import circle_pkg::*; (
    input  logic    vif,
    input  logic    arst_n,
    input  logic    start,
    input  xcoord_t centre_x,
    input  ycoord_t centre_y,
    input  radius_t radius,
    input  colour_t colour,
    input  logic    skip_clear,
    output logic    done,
    output logic    plot,
    output xcoord_t x,
    output ycoord_t y,
    output colour_t plot_colour
);

    circle_req_t req_in;
    // Latched copy for the engines
    circle_req_t req;

    // Engine handshakes
    logic        clear_go;
    logic        clear_fin;
    logic        draw_go;
    logic        draw_fin;
    logic        drawing;

    // Point streams into the clip stage
    logic        clr_valid;
    point_t      clr_pt;
    logic        drw_valid;
    point_t      drw_pt;

    assign req_in = '{
        centre_x:   centre_x,
        centre_y:   centre_y,
        radius:     radius,
        colour:     colour,
        skip_clear: skip_clear
    };

    circle_cmd i_circle_cmd (
        .vif       (vif),
        .arst_n    (arst_n),
        .start     (start),
        .req_in    (req_in),
        .done      (done),
        .req       (req),
        .clear_go  (clear_go),
        .draw_go   (draw_go),
        .clear_fin (clear_fin),
        .draw_fin  (draw_fin),
        .drawing   (drawing)
    );

    screen_clear i_screen_clear (
        .vif       (vif),
        .arst_n    (arst_n),
        .clear_go  (clear_go),
        .clear_fin (clear_fin),
        .pt_valid  (clr_valid),
        .pt        (clr_pt)
    );

    circle_octants i_circle_octants (
        .vif      (vif),
        .arst_n   (arst_n),
        .draw_go  (draw_go),
        .req      (req),
        .draw_fin (draw_fin),
        .pt_valid (drw_valid),
        .pt       (drw_pt)
    );

    // Single registered pixel port
    pixel_clip i_pixel_clip (
        .vif         (vif),
        .arst_n      (arst_n),
        .drawing     (drawing),
        .colour      (req.colour),
        .clr_valid   (clr_valid),
        .clr_pt      (clr_pt),
        .drw_valid   (drw_valid),
        .drw_pt      (drw_pt),
        .plot        (plot),
        .x           (x),
        .y           (y),
        .plot_colour (plot_colour)
    );

endmodule

//--- source/pixel_clip.sv
`timescale 1ns/1ps

module pixel_clip import circle_pkg::*; (
    input  logic    vif,
    input  logic    arst_n,
    input  logic    drawing,
    input  colour_t colour,
    input  logic    clr_valid,
    input  point_t  clr_pt,
    input  logic    drw_valid,
    input  point_t  drw_pt,
    output logic    plot,
    output xcoord_t x,
    output ycoord_t y,
    output colour_t plot_colour
);

    logic   sel_valid;
    point_t sel_pt;
    logic   in_range;

    // Circle engine while drawing, clear sweep otherwise
    assign sel_valid = drawing ? drw_valid : clr_valid;
    assign sel_pt    = drawing ? drw_pt : clr_pt;

    // Sign bit clear rules out points left of or above the screen
    assign in_range = !sel_pt.x[9] && (sel_pt.x < scoord_t'(scr_w))
                   && !sel_pt.y[9] && (sel_pt.y < scoord_t'(scr_h));

    // Off-screen points are dropped here
    always_ff @(posedge vif or negedge arst_n) begin
        if (!arst_n) begin
            plot <= 1'b0;
        end else begin
            plot <= sel_valid && in_range;
        end
    end

    // Pixel payload
    always_ff @(posedge vif) begin
        if (sel_valid && in_range) begin
            x           <= sel_pt.x[7:0];
            y           <= sel_pt.y[6:0];
            // Clear writes black
            plot_colour <= drawing ? colour : '0;
        end
    end

endmodule

//--- source/screen_clear.sv
`timescale 1ns/1ps

module screen_clear import circle_pkg::*; (
    input  logic   vif,
    input  logic   arst_n,
    input  logic   clear_go,
    output logic   clear_fin,
    output logic   pt_valid,
    output point_t pt
);

    logic       active;
    // Raster position, x fastest
    logic [7:0] x_cnt;
    logic [6:0] y_cnt;
    logic       last_x;
    logic       last_y;

    // End of row and end of frame
    assign last_x = (x_cnt == 8'(scr_w - 1));
    assign last_y = (y_cnt == 7'(scr_h - 1));

    always_ff @(posedge vif or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            x_cnt  <= '0;
            y_cnt  <= '0;
        end else if (clear_go) begin
            // Restart from the top left corner
            active <= 1'b1;
            x_cnt  <= '0;
            y_cnt  <= '0;
        end else if (active) begin
            if (last_x) begin
                x_cnt <= '0;
                if (last_y) begin
                    // Whole frame swept
                    active <= 1'b0;
                    y_cnt  <= '0;
                end else begin
                    y_cnt <= y_cnt + 7'd1;
                end
            end else begin
                x_cnt <= x_cnt + 8'd1;
            end
        end
    end

    // One pixel per cycle while sweeping
    assign pt_valid  = active;
    // Flags the bottom right pixel as it goes out
    assign clear_fin = active && last_x && last_y;

    // Zero-extended into the signed point format
    assign pt.x = {2'b00, x_cnt};
    assign pt.y = {3'b000, y_cnt};

endmodule

//--- verif/circle_tb.sv
`timescale 1ns/1ps

module circle_tb import circle_pkg::*; ();

    // Full clear plus the longest circle, with margin
    localparam int done_limit = scr_w * scr_h + 4000;

    logic    vif;
    logic    arst_n;
    logic    start;
    xcoord_t centre_x;
    ycoord_t centre_y;
    radius_t radius;
    colour_t colour;
    logic    skip_clear;
    logic    done;
    logic    plot;
    xcoord_t x;
    ycoord_t y;
    colour_t plot_colour;

    // Screen as written through the plot port
    colour_t frame     [scr_w][scr_h];
    // Screen as predicted from the requests
    colour_t exp_frame [scr_w][scr_h];

    // On-screen circle points of the current request, emission order
    int      exp_x [$];
    int      exp_y [$];

    // Progress of the current request
    int      busy;
    int      clear_total;
    int      clear_pos;
    int      circ_cnt;
    int      cur_colour;
    // Clock edges since the edge that raised start
    int      since_start;

    circle_top i_circle_top (
        .vif         (vif),
        .arst_n      (arst_n),
        .start       (start),
        .centre_x    (centre_x),
        .centre_y    (centre_y),
        .radius      (radius),
        .colour      (colour),
        .skip_clear  (skip_clear),
        .done        (done),
        .plot        (plot),
        .x           (x),
        .y           (y),
        .plot_colour (plot_colour)
    );

    // 8 ns clock
    initial begin
        vif = 1'b0;
        forever #4 vif = ~vif;
    end

    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_eq(int got, int expected, string what);
        if (got != expected) begin
            $display("Fail at %0t: %s, got %0d, expected %0d", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    // Midpoint rule, keeping only points that land on the screen
    task automatic build_expected(int cx, int cy, int r);
        int a;
        int b;
        int d;
        int k;
        int u;
        int v;
        int px;
        int py;
        exp_x.delete();
        exp_y.delete();
        a = r;
        b = 0;
        d = 1 - r;
        while (b <= a) begin
            // (a, b) then (b, a), signs ++ -+ +- --
            for (k = 0; k < 8; k++) begin
                u  = (k < 4) ? a : b;
                v  = (k < 4) ? b : a;
                px = (k % 2 == 0) ? cx + u : cx - u;
                py = ((k / 2) % 2 == 0) ? cy + v : cy - v;
                if (px >= 0 && px < scr_w && py >= 0 && py < scr_h) begin
                    exp_x.push_back(px);
                    exp_y.push_back(py);
                end
            end
            b++;
            if (d < 0) begin
                d = d + 2 * b + 1;
            end else begin
                a--;
                d = d + 2 * (b - a) + 1;
            end
        end
    endtask

    // Scoreboard for one plot strobe
    task automatic observe_plot();
        check_eq(busy, 1, "plot with no request pending");
        check_eq(int'(done), 0, "plot while done is high");
        check_eq(int'(x) < scr_w ? 1 : 0, 1, "plot x off screen");
        check_eq(int'(y) < scr_h ? 1 : 0, 1, "plot y off screen");
        frame[x][y] = plot_colour;
        if (clear_pos < clear_total) begin
            // Raster order, black, first pixel soon after start
            if (clear_pos == 0) begin
                check_eq(since_start <= 4 ? 1 : 0, 1, "first clear pixel too late");
            end
            check_eq(int'(plot_colour), 0, "clear pixel colour");
            check_eq(int'(x), clear_pos % scr_w, "clear pixel x");
            check_eq(int'(y), clear_pos / scr_w, "clear pixel y");
            clear_pos++;
        end else begin
            check_eq(circ_cnt < exp_x.size() ? 1 : 0, 1, "circle plot beyond expected list");
            check_eq(int'(x), exp_x[circ_cnt], "circle pixel x");
            check_eq(int'(y), exp_y[circ_cnt], "circle pixel y");
            check_eq(int'(plot_colour), cur_colour, "circle pixel colour");
            circ_cnt++;
        end
    endtask

    // Outputs sampled mid-cycle on the falling edge
    task automatic next_cycle();
        @(negedge vif);
        since_start++;
        if (plot) begin
            observe_plot();
        end
    endtask

    task automatic run_request(int cx, int cy, int r, int col, int skip, int count);
        int i;
        int j;
        int k;
        int gap;
        int hold;
        int cycles;
        build_expected(cx, cy, r);
        if (skip == 0) begin
            for (i = 0; i < scr_w; i++) begin
                for (j = 0; j < scr_h; j++) begin
                    exp_frame[i][j] = '0;
                end
            end
        end
        // Later writes win, as on the real screen
        for (k = 0; k < exp_x.size(); k++) begin
            exp_frame[exp_x[k]][exp_y[k]] = colour_t'(col);
        end
        clear_total = (skip == 0) ? scr_w * scr_h : 0;
        clear_pos   = 0;
        circ_cnt    = 0;
        cur_colour  = col;

        // Random idle gap between requests
        gap = $urandom % 6;
        repeat (gap) next_cycle();
        check_eq(int'(done), 0, "done before start");

        @(posedge vif);
        centre_x    <= xcoord_t'(cx);
        centre_y    <= ycoord_t'(cy);
        radius      <= radius_t'(r);
        colour      <= colour_t'(col);
        skip_clear  <= (skip != 0);
        start       <= 1'b1;
        busy        = 1;
        since_start = 0;
        next_cycle();

        cycles = 0;
        while (!done) begin
            if (cycles == done_limit) begin
                $display("Timeout: done did not rise within %0d cycles", done_limit);
                stop_on_failure();
            end
            next_cycle();
            cycles++;
        end

        // Every plot has left before done
        check_eq(clear_pos, clear_total, "clear pixels before done");
        check_eq(circ_cnt, exp_x.size(), "circle pixels before done");
        if (count >= 0) begin
            check_eq(circ_cnt, count, "circle writes against vector file");
        end
        for (i = 0; i < scr_w; i++) begin
            for (j = 0; j < scr_h; j++) begin
                if (frame[i][j] != exp_frame[i][j]) begin
                    check_eq(int'(frame[i][j]), int'(exp_frame[i][j]),
                             $sformatf("pixel (%0d, %0d) after request", i, j));
                end
            end
        end

        // done holds while start stays high
        hold = 1 + $urandom % 4;
        repeat (hold) begin
            next_cycle();
            check_eq(int'(done), 1, "done dropped while start held");
        end
        @(posedge vif);
        start <= 1'b0;
        next_cycle();
        check_eq(int'(done), 1, "done fell before start was seen low");
        next_cycle();
        check_eq(int'(done), 0, "done still high after start dropped");
        busy = 0;
    endtask

    initial begin
        int    fd;
        int    n;
        int    reqs;
        int    vcx;
        int    vcy;
        int    vr;
        int    vcol;
        int    vskip;
        int    vcount;
        string line;
        void'($urandom(32'hfd2a_12ca));
        arst_n      = 1'b0;
        start       = 1'b0;
        centre_x    = '0;
        centre_y    = '0;
        radius      = '0;
        colour      = '0;
        skip_clear  = 1'b0;
        busy        = 0;
        clear_total = 0;
        clear_pos   = 0;
        circ_cnt    = 0;
        cur_colour  = 0;
        since_start = 0;
        for (n = 0; n < scr_w * scr_h; n++) begin
            frame[n % scr_w][n / scr_w]     = '0;
            exp_frame[n % scr_w][n / scr_w] = '0;
        end

        // Reset for 4 cycles
        repeat (4) @(posedge vif);
        arst_n <= 1'b1;
        next_cycle();
        check_eq(int'(done), 0, "done after reset");
        check_eq(int'(plot), 0, "plot after reset");

        fd = $fopen("verif/circle_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/circle_vectors.txt");
            stop_on_failure();
        end
        reqs = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines yield no fields
            n = $sscanf(line, "%d %d %d %d %d %d", vcx, vcy, vr, vcol, vskip, vcount);
            if (n == 6) begin
                run_request(vcx, vcy, vr, vcol, vskip, vcount);
                reqs++;
            end else if (n > 0) begin
                $display("Malformed vector line: %s", line);
                stop_on_failure();
            end
        end
        $fclose(fd);
        check_eq(reqs > 0 ? 1 : 0, 1, "requests read from vector file");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- verif/circle_vectors.txt
# centre_x centre_y radius colour skip_clear expected_circle_writes (decimal)
# expected_circle_writes of -1 leaves the count to the reference model alone
80 60 30 2 0 -1
90 60 30 5 1 -1
37 91 14 3 1 -1
121 22 47 6 0 -1
12 103 88 1 1 -1
143 57 5 7 1 -1
66 14 120 4 1 -1
101 77 2 3 1 -1
54 40 19 6 1 -1
150 110 33 2 1 -1
0 0 0 1 0 8
0 0 1 2 1 4
0 0 255 3 1 0
159 0 0 4 1 8
159 0 1 5 1 4
159 0 255 6 1 0
0 119 0 7 1 8
0 119 1 1 1 4
0 119 255 2 1 0
159 119 0 3 1 8
159 119 1 4 1 4
159 119 255 5 1 0
80 0 0 6 1 8
80 0 1 7 1 6
0 60 1 3 1 6
159 60 1 5 1 6
80 119 1 7 1 6
80 119 255 1 1 0
0 60 255 4 0 0
80 60 59 3 0 -1
80 60 60 4 1 -1
80 60 61 5 1 -1
80 60 79 6 0 -1
80 60 80 7 1 -1
80 60 81 1 1 -1
45 30 1 2 1 8
100 100 0 3 1 8
70 50 40 5 0 -1
